//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = store_subsystem_tb
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# Build, run, and decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
verilog/cpu_types_pkg.sv
verilog/memory_map_pkg.sv
verilog/store_buffer.sv
verilog/store_unit.sv
verilog/machine_timer.sv
verilog/store_subsystem.sv
test/store_subsystem_tb.sv

//--- test/store_subsystem_tb.sv
// ====================
// Testbench for the store path that drives table rows against a modelled
// memory controller and checks forwarding, flush, full buffer and timer behavior
// ====================
module store_subsystem_tb
    import cpu_types_pkg::*;
    import memory_map_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS = 16;

    // ====================
    // DUT and its signals
    // ====================

    logic         clk_i, rst_n_i, flush_i;
    logic         valid_operation_i, wait_i, validate_i;
    data_word_t   store_data_i, store_address_i;
    stu_uop_t     operation_i;
    logic [29:0]  forward_address_i;
    data_word_t   forward_data_o;
    logic         forward_match_o, buffer_empty_o, idle_o;
    logic         data_valid_o, illegal_access_o;
    logic         store_request_o, store_done_i, timer_interrupt_o;
    data_word_t   store_address_o, store_data_o;
    store_width_t store_width_o;

    // Every port of the top level has a signal of the same name here
    store_subsystem dut0 (.*);

    always #2 clk_i = ~clk_i;

    // Own cycle counter that equals mtime in every cycle after reset release
    logic [63:0] cycle_count;

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 64'd1;
        end
    end

    // ====================
    // Stimulus table
    // ====================

    typedef enum {K_STORE, K_FORWARD, K_FLUSH, K_DRAIN, K_FILL, K_TIMER} row_kind_t;

    typedef struct {
        string      name;
        row_kind_t  kind;
        data_word_t address;
        data_word_t data;
        stu_uop_t   width;
        logic       validate;
        logic       exp_illegal;
        logic       exp_match;
    } row_t;

    row_t rows [NUM_ROWS];

    // Retired memory writes and the writes the table predicts as {width, address, data}
    logic [65:0] retired_q  [$];
    logic [65:0] expected_q [$];

    logic  hold_memory;
    string current_test;
    int    error_count;

    // Flags are {validate, expected illegal, expected forward match}
    task automatic set_row(input int r, input string name, input row_kind_t kind,
                           input data_word_t address, input data_word_t data,
                           input stu_uop_t width, input logic [2:0] flags);
        rows[r].name        = name;
        rows[r].kind        = kind;
        rows[r].address     = address;
        rows[r].data        = data;
        rows[r].width       = width;
        rows[r].validate    = flags[2];
        rows[r].exp_illegal = flags[1];
        rows[r].exp_match   = flags[0];
    endtask

    task automatic build_table();
        set_row(0,  "st_word",      K_STORE,   32'h4000, 32'h1111_2222, STORE_WORD, 3'b100);
        set_row(1,  "st_half",      K_STORE,   32'h4006, 32'h0000_BEEF, STORE_HALF, 3'b100);
        set_row(2,  "st_byte",      K_STORE,   32'h4009, 32'h0000_0055, STORE_BYTE, 3'b100);
        set_row(3,  "drain_basic",  K_DRAIN,   32'h0,    32'h0,         STORE_WORD, 3'b000);
        set_row(4,  "fl_val_a",     K_STORE,   32'h7000, 32'hA0A0_0001, STORE_WORD, 3'b100);
        set_row(5,  "fl_val_b",     K_STORE,   32'h7004, 32'hA0A0_0002, STORE_WORD, 3'b100);
        set_row(6,  "spec_old",     K_STORE,   32'h5000, 32'h1234_5678, STORE_WORD, 3'b000);
        set_row(7,  "spec_young",   K_STORE,   32'h5002, 32'hCAFE_F00D, STORE_HALF, 3'b000);
        // Both speculative stores hit word 0x1400 and the younger one must win
        set_row(8,  "fwd_youngest", K_FORWARD, 32'h5001, 32'hCAFE_F00D, STORE_WORD, 3'b001);
        set_row(9,  "fwd_miss",     K_FORWARD, 32'h6000, 32'h0,         STORE_WORD, 3'b000);
        set_row(10, "flush_spec",   K_FLUSH,   32'h0,    32'h0,         STORE_WORD, 3'b000);
        set_row(11, "boot_store",   K_STORE,   32'h0800, 32'hDEAD_BEEF, STORE_WORD, 3'b010);
        set_row(12, "drain_boot",   K_DRAIN,   32'h0,    32'h0,         STORE_WORD, 3'b000);
        set_row(13, "fill_nine",    K_FILL,    32'h8000, 32'hF000_0000, STORE_WORD, 3'b000);
        // Data holds the distance in cycles from now to the compare value
        set_row(14, "timer_cmp",    K_TIMER,   32'h0,    32'd40,        STORE_WORD, 3'b000);
        set_row(15, "drain_final",  K_DRAIN,   32'h0,    32'h0,         STORE_WORD, 3'b000);
    endtask

    // ====================
    // Checks and helpers
    // ====================

    task automatic check_value(input string what, input logic [65:0] expected,
                               input logic [65:0] actual);
        assert (expected === actual) else begin
            $display("ERROR %s %s: expected %0h actual %0h", current_test, what,
                     expected, actual);
            error_count++;
        end
    endtask

    task automatic report_problem(input string message);
        $display("Problem in %s: %s", current_test, message);
        error_count++;
    endtask

    // Moves to the drive point 1 ns after the rising edge
    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    // Presents one store and waits for data_valid_o while it counts the cycles spent stalled
    // Starts and ends at a drive point
    task automatic issue_store(input data_word_t address, input data_word_t data,
                               input stu_uop_t width, output logic illegal_seen,
                               output int stalls);
        stalls            = 0;
        valid_operation_i = 1'b1;
        store_address_i   = address;
        store_data_i      = data;
        operation_i       = width;
        #1;
        while (!data_valid_o) begin
            assert (!idle_o) else report_problem("idle_o was high while a store was stalled");
            // Let memory retire again once the stall has been seen for a while
            if (hold_memory && stalls == 4) begin
                hold_memory = 1'b0;
            end
            tick();
            valid_operation_i = 1'b0;
            stalls++;
            #1;
        end
        illegal_seen = illegal_access_o;
        tick();
        valid_operation_i = 1'b0;
    endtask

    task automatic validate_pulse();
        validate_i = 1'b1;
        tick();
        validate_i = 1'b0;
    endtask

    // Waits for the buffer to empty and then compares memory writes in order
    task automatic drain_and_compare();
        while (!buffer_empty_o) begin
            tick();
        end
        assert (retired_q.size() == expected_q.size()) else begin
            report_problem($sformatf("memory saw %0d stores but %0d were expected",
                                     retired_q.size(), expected_q.size()));
        end
        for (int i = 0; i < retired_q.size() && i < expected_q.size(); i++) begin
            check_value($sformatf("memory write %0d", i), expected_q[i], retired_q[i]);
        end
        retired_q.delete();
        expected_q.delete();
    endtask

    // ====================
    // Memory controller model
    // ====================

    // Retires the offered store after 0 to 5 cycles unless held off
    initial begin : memory_responder
        int unsigned delay;

        delay        = $urandom(35196);
        store_done_i = 1'b0;
        forever begin
            tick();
            if (rst_n_i && store_request_o && !hold_memory) begin
                delay = $urandom % 6;
                for (int i = 0; i < delay; i++) begin
                    tick();
                end
                retired_q.push_back({store_width_o, store_address_o, store_data_o});
                store_done_i = 1'b1;
                tick();
                store_done_i = 1'b0;
            end
        end
    end

    // ====================
    // Row scenarios
    // ====================

    // Nine stores with memory held off so the ninth must wait for a free entry
    task automatic run_fill(input int r);
        data_word_t address, data;
        logic       illegal;
        int         stalls;

        hold_memory = 1'b1;
        for (int i = 0; i < 9; i++) begin
            address = rows[r].address + 32'(4 * i);
            data    = rows[r].data + 32'(i) * 32'h0101_0101;
            issue_store(address, data, STORE_WORD, illegal, stalls);
            check_value("illegal_access_o", 66'(0), 66'(illegal));
            if (i < 8) begin
                check_value("stall cycles", 66'(0), 66'(stalls));
            end else begin
                assert (stalls > 4) else report_problem("ninth store did not wait for a retire");
            end
            validate_pulse();
            expected_q.push_back({STORE_WORD, address, data});
        end
        drain_and_compare();
    endtask

    // Programs mtimecmp ahead of the cycle counter and watches the interrupt
    task automatic run_timer(input int r);
        logic [63:0] target;
        logic        illegal;
        int          stalls;

        target = cycle_count + 64'(rows[r].data);
        // High half first so the half written compare never lands in the past
        issue_store(TIMER_START + MTIMECMP_HIGH_OFFSET, target[63:32], STORE_WORD,
                    illegal, stalls);
        issue_store(TIMER_START + MTIMECMP_LOW_OFFSET, target[31:0], STORE_WORD,
                    illegal, stalls);
        check_value("timer store illegal_access_o", 66'(0), 66'(illegal));
        check_value("timer store stall cycles", 66'(0), 66'(stalls));
        while (cycle_count <= target + 64'd2) begin
            #1;
            // The compare is registered so the level is high only once mtime has passed the target
            check_value("timer_interrupt_o", 66'(cycle_count > target),
                        66'(timer_interrupt_o));
            tick();
        end
    endtask

    task automatic run_row(input int r);
        logic illegal;
        int   stalls;

        case (rows[r].kind)
            K_STORE: begin
                issue_store(rows[r].address, rows[r].data, rows[r].width, illegal, stalls);
                check_value("illegal_access_o", 66'(rows[r].exp_illegal), 66'(illegal));
                check_value("stall cycles", 66'(0), 66'(stalls));
                if (rows[r].exp_illegal) begin
                    assert (buffer_empty_o) else report_problem("boot store entered the buffer");
                end
                if (rows[r].validate) begin
                    validate_pulse();
                    expected_q.push_back({rows[r].width, rows[r].address, rows[r].data});
                end
            end
            K_FORWARD: begin
                forward_address_i = rows[r].address[31:2];
                #1;
                check_value("forward_match_o", 66'(rows[r].exp_match), 66'(forward_match_o));
                if (rows[r].exp_match) begin
                    check_value("forward_data_o", 66'(rows[r].data), 66'(forward_data_o));
                end
                tick();
            end
            K_FLUSH: begin
                flush_i = 1'b1;
                tick();
                flush_i = 1'b0;
                assert (idle_o) else report_problem("store unit not idle after flush");
                drain_and_compare();
            end
            K_DRAIN: drain_and_compare();
            K_FILL:  run_fill(r);
            K_TIMER: run_timer(r);
            default: report_problem("unknown row kind");
        endcase
    endtask

    // ====================
    // Main sequence and watchdog
    // ====================

    initial begin : main
        int errors_before;
        int passed;
        int failed;

        clk_i             = 1'b0;
        rst_n_i           = 1'b0;
        flush_i           = 1'b0;
        valid_operation_i = 1'b0;
        wait_i            = 1'b0;
        validate_i        = 1'b0;
        store_data_i      = '0;
        store_address_i   = '0;
        operation_i       = '0;
        forward_address_i = '0;
        hold_memory       = 1'b0;
        error_count       = 0;
        passed            = 0;
        failed            = 0;
        current_test      = "reset";
        build_table();

        repeat (8) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        tick();

        for (int r = 0; r < NUM_ROWS; r++) begin
            current_test  = rows[r].name;
            errors_before = error_count;
            run_row(r);
            if (error_count == errors_before) begin
                $display("PASS %s", rows[r].name);
                passed++;
            end else begin
                $display("FAIL %s", rows[r].name);
                failed++;
            end
        end

        $display("%0d tests run, %0d passed, %0d failed", NUM_ROWS, passed, failed);
        if (failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // About 200 ns per row is far more than the slowest row needs
    initial begin : watchdog
        #(NUM_ROWS * 200);
        $display("Watchdog expired in %s, the run did not finish in time", current_test);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule : store_subsystem_tb

//--- verilog/cpu_types_pkg.sv
// ====================
// Core data types for the execution stage store path
// ====================
package cpu_types_pkg;

    // ====================
    // Data words
    // ====================

    // Width of both data and address words of the core
    localparam int XLEN = 32;

    // Plain data or address word
    typedef logic [XLEN-1:0] data_word_t;

    // ====================
    // Store encodings
    // ====================

    // Number of bytes written by a store, matches funct3[1:0] of the ISA
    typedef enum logic [1:0] {
        STORE_BYTE = 2'b00,
        STORE_HALF = 2'b01,
        STORE_WORD = 2'b10
    } store_width_t;

    // Store micro-operation issued by the decoder
    // It shares the encoding of store_width_t so a cast recovers the width
    typedef logic [1:0] stu_uop_t;

    // ====================
    // Store buffer sizing
    // ====================

    // Number of entries in the speculative store buffer, must be a power of two
    localparam int STORE_BUFFER_DEPTH = 8;

endpackage : cpu_types_pkg

//--- verilog/machine_timer.sv
// ====================
// Machine timer with mtime counter, mtimecmp register and interrupt level
// ====================
module machine_timer
    import cpu_types_pkg::*;
    import memory_map_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    // Single cycle write from the store unit
    input  logic       timer_write_i,
    input  data_word_t timer_address_i,
    input  data_word_t timer_data_i,

    output logic       timer_interrupt_o
);

    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    data_word_t  offset;

    // Register offset inside the timer block
    assign offset = timer_address_i - TIMER_START;

    // ====================
    // Counter
    // ====================

    // Free running, zero in the first cycle after reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // ====================
    // Compare register
    // ====================

    // All ones keeps the interrupt quiet until software programs it
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mtimecmp_q <= '1;
        end else if (timer_write_i) begin
            if (offset == MTIMECMP_LOW_OFFSET) begin
                mtimecmp_q[31:0] <= timer_data_i;
            end else if (offset == MTIMECMP_HIGH_OFFSET) begin
                mtimecmp_q[63:32] <= timer_data_i;
            end
        end
    end

    // Level interrupt, one cycle behind the compare
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            timer_interrupt_o <= 1'b0;
        end else begin
            timer_interrupt_o <= (mtime_q >= mtimecmp_q);
        end
    end

endmodule : machine_timer

//--- verilog/memory_map_pkg.sv
// ====================
// System memory map seen by the store path
// ====================
package memory_map_pkg;

    // Boot ROM sits at the bottom of the address space
    // Every address below this bound is read only
    localparam logic [31:0] BOOT_END = 32'h0000_1000;

    // Machine timer register block, both bounds are inclusive
    localparam logic [31:0] TIMER_START = 32'h0000_2000;
    localparam logic [31:0] TIMER_END   = 32'h0000_200F;

    // Byte offsets inside the timer block
    // The mtime counter itself lives at offsets 0x0 and 0x4 and is read only here
    localparam logic [31:0] MTIMECMP_LOW_OFFSET  = 32'h0000_0008;
    localparam logic [31:0] MTIMECMP_HIGH_OFFSET = 32'h0000_000C;

    // Anything above the timer block and not in boot ROM is cacheable memory
    // and goes through the store buffer

endpackage : memory_map_pkg

//--- verilog/store_buffer.sv
// ====================
// Speculative store buffer that drains committed stores in order
// and forwards pending data to loads
// ====================
module store_buffer
    import cpu_types_pkg::*;
#(
    parameter int DEPTH = STORE_BUFFER_DEPTH
) (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,

    // Push port from the store unit FSM
    input  logic         push_i,
    input  data_word_t   push_data_i,
    input  data_word_t   push_address_i,
    input  store_width_t push_width_i,
    output logic         full_o,
    output logic         empty_o,

    // Commit of the oldest speculative entry
    input  logic         validate_i,

    // Memory controller store channel
    output logic         store_request_o,
    output data_word_t   store_address_o,
    output data_word_t   store_data_o,
    output store_width_t store_width_o,
    input  logic         store_done_i,

    // Load forwarding, word addressed
    input  logic [29:0]  forward_address_i,
    output data_word_t   forward_data_o,
    output logic         forward_match_o
);

    localparam int PTR_W = $clog2(DEPTH);

    // ====================
    // Queue pointers
    // ====================

    // Pointers carry one extra wrap bit so that full and empty differ
    // Head is the oldest entry, commit is the first speculative one, tail is the next free slot
    logic [PTR_W:0] head_q, commit_q, tail_q;
    logic [PTR_W:0] commit_next;
    logic [PTR_W:0] used;
    logic           push_ok;
    logic           validate_ok;
    logic           retire_ok;

    // Occupied entries, committed ones included
    assign used    = tail_q - head_q;
    assign full_o  = (used == (PTR_W+1)'(DEPTH));
    assign empty_o = (tail_q == head_q);

    assign push_ok     = push_i && !full_o;
    assign validate_ok = validate_i && (tail_q != commit_q);
    assign retire_ok   = store_done_i && store_request_o;

    // A validate in the same cycle as a flush still commits its entry
    assign commit_next = validate_ok ? commit_q + 1'b1 : commit_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q   <= '0;
            commit_q <= '0;
            tail_q   <= '0;
        end else begin
            commit_q <= commit_next;

            if (retire_ok) begin
                head_q <= head_q + 1'b1;
            end

            // Flush throws away every speculative entry and any store pushed now
            if (flush_i) begin
                tail_q <= commit_next;
            end else if (push_ok) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    // ====================
    // Entry storage
    // ====================

    data_word_t   data_q    [DEPTH];
    data_word_t   address_q [DEPTH];
    store_width_t width_q   [DEPTH];

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            data_q[tail_q[PTR_W-1:0]]    <= push_data_i;
            address_q[tail_q[PTR_W-1:0]] <= push_address_i;
            width_q[tail_q[PTR_W-1:0]]   <= push_width_i;
        end
    end

    // ====================
    // Drain port
    // ====================

    // The oldest entry is offered as long as it has been committed
    // Outputs stay stable because head only moves on store_done_i
    assign store_request_o = (head_q != commit_q);
    assign store_address_o = address_q[head_q[PTR_W-1:0]];
    assign store_data_o    = data_q[head_q[PTR_W-1:0]];
    assign store_width_o   = width_q[head_q[PTR_W-1:0]];

    // ====================
    // Forwarding
    // ====================

    // Walk from oldest to youngest so a later match overrides an earlier one
    always_comb begin : forward_search
        logic [PTR_W-1:0] slot;

        forward_match_o = 1'b0;
        forward_data_o  = '0;

        for (int i = 0; i < DEPTH; i++) begin
            slot = head_q[PTR_W-1:0] + PTR_W'(i);

            if ((i < int'(used)) && (address_q[slot][31:2] == forward_address_i)) begin
                forward_match_o = 1'b1;
                forward_data_o  = data_q[slot];
            end
        end
    end : forward_search

    // ====================
    // Protocol checks
    // ====================

    // The producer must look at full_o before pushing
    no_push_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o
    ) else $error("store_buffer: push while full");

    // The pipeline only validates stores that were actually issued
    no_orphan_validate: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) validate_i |-> (tail_q != commit_q)
    ) else $error("store_buffer: validate with no speculative entry");

    // Memory side may only retire an entry that is being offered
    done_needs_request: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) store_done_i |-> store_request_o
    ) else $error("store_buffer: store_done_i without request");

endmodule : store_buffer

//--- verilog/store_subsystem.sv
// ====================
// Store path top level joining the store unit and the machine timer
// ====================
module store_subsystem
    import cpu_types_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,

    // Pipeline side
    input  logic         valid_operation_i,
    input  data_word_t   store_data_i,
    input  data_word_t   store_address_i,
    input  stu_uop_t     operation_i,
    input  logic         wait_i,
    input  logic         validate_i,
    input  logic [29:0]  forward_address_i,
    output data_word_t   forward_data_o,
    output logic         forward_match_o,
    output logic         buffer_empty_o,
    output logic         idle_o,
    output logic         data_valid_o,
    output logic         illegal_access_o,

    // Memory controller store channel
    output logic         store_request_o,
    output data_word_t   store_address_o,
    output data_word_t   store_data_o,
    output store_width_t store_width_o,
    input  logic         store_done_i,

    output logic         timer_interrupt_o
);

    // Timer write bus between the two blocks
    logic       timer_write;
    data_word_t timer_address, timer_data;

    store_unit store_unit0 (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .valid_operation_i (valid_operation_i),
        .store_data_i      (store_data_i),
        .store_address_i   (store_address_i),
        .operation_i       (operation_i),
        .wait_i            (wait_i),
        .validate_i        (validate_i),
        .forward_address_i (forward_address_i),
        .forward_data_o    (forward_data_o),
        .forward_match_o   (forward_match_o),
        .buffer_empty_o    (buffer_empty_o),
        .idle_o            (idle_o),
        .data_valid_o      (data_valid_o),
        .illegal_access_o  (illegal_access_o),
        .timer_write_o     (timer_write),
        .timer_address_o   (timer_address),
        .timer_data_o      (timer_data),
        .store_request_o   (store_request_o),
        .store_address_o   (store_address_o),
        .store_data_o      (store_data_o),
        .store_width_o     (store_width_o),
        .store_done_i      (store_done_i)
    );

    machine_timer machine_timer0 (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .timer_write_i     (timer_write),
        .timer_address_i   (timer_address),
        .timer_data_i      (timer_data),
        .timer_interrupt_o (timer_interrupt_o)
    );

endmodule : store_subsystem

//--- verilog/store_unit.sv
// ====================
// Store unit FSM that routes each store to the buffer, the timer or an access fault
// ====================
module store_unit
    import cpu_types_pkg::*;
    import memory_map_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,

    // Issue side from the pipeline
    input  logic         valid_operation_i,
    input  data_word_t   store_data_i,
    input  data_word_t   store_address_i,
    input  stu_uop_t     operation_i,
    input  logic         wait_i,
    input  logic         validate_i,

    // Load forwarding
    input  logic [29:0]  forward_address_i,
    output data_word_t   forward_data_o,
    output logic         forward_match_o,

    // Status back to the pipeline
    output logic         buffer_empty_o,
    output logic         idle_o,
    output logic         data_valid_o,
    output logic         illegal_access_o,

    // Memory mapped timer write
    output logic         timer_write_o,
    output data_word_t   timer_address_o,
    output data_word_t   timer_data_o,

    // Memory controller store channel
    output logic         store_request_o,
    output data_word_t   store_address_o,
    output data_word_t   store_data_o,
    output store_width_t store_width_o,
    input  logic         store_done_i
);

    // ====================
    // Address decode
    // ====================

    logic boot_access, timer_access;

    assign boot_access  = (store_address_i < BOOT_END);
    assign timer_access = (store_address_i >= TIMER_START) && (store_address_i <= TIMER_END);

    // Timer writes go out straight from the issue operands
    assign timer_address_o = store_address_i;
    assign timer_data_o    = store_data_i;

    // ====================
    // FSM
    // ====================

    typedef enum logic [1:0] {IDLE, WAIT_BUFFER, WAIT_ACCEPT} stu_state_t;

    stu_state_t state_q, state_d;

    // Operands kept for a store stalled on a full buffer
    data_word_t   held_data_q, held_address_q;
    store_width_t held_width_q;
    logic         held_illegal_q;

    logic         push, buffer_full, issue_done;
    data_word_t   push_data, push_address;
    store_width_t push_width;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Only a new store in IDLE overwrites the held operands
    always_ff @(posedge clk_i) begin
        if ((state_q == IDLE) && valid_operation_i) begin
            held_data_q    <= store_data_i;
            held_address_q <= store_address_i;
            held_width_q   <= store_width_t'(operation_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            held_illegal_q <= 1'b0;
        end else if ((state_q == IDLE) && valid_operation_i) begin
            held_illegal_q <= boot_access;
        end
    end

    always_comb begin
        state_d          = state_q;
        push             = 1'b0;
        push_data        = store_data_i;
        push_address     = store_address_i;
        push_width       = store_width_t'(operation_i);
        issue_done       = 1'b0;
        idle_o           = 1'b0;
        data_valid_o     = 1'b0;
        illegal_access_o = 1'b0;
        timer_write_o    = 1'b0;

        case (state_q)
            IDLE: begin
                idle_o = 1'b1;

                if (valid_operation_i) begin
                    // The boot region wins over everything and nothing gets written
                    if (boot_access) begin
                        illegal_access_o = 1'b1;
                        issue_done       = 1'b1;
                    end else if (timer_access) begin
                        timer_write_o = 1'b1;
                        issue_done    = 1'b1;
                    end else if (!buffer_full) begin
                        push       = 1'b1;
                        issue_done = 1'b1;
                    end else begin
                        state_d = WAIT_BUFFER;
                        idle_o  = 1'b0;
                    end

                    // While writeback is busy the result stays up until it is taken
                    data_valid_o = issue_done;
                    if (issue_done && wait_i) begin
                        state_d = WAIT_ACCEPT;
                        idle_o  = 1'b0;
                    end
                end
            end

            WAIT_BUFFER: begin
                push         = !buffer_full;
                push_data    = held_data_q;
                push_address = held_address_q;
                push_width   = held_width_q;

                if (!buffer_full) begin
                    data_valid_o = 1'b1;
                    if (wait_i) begin
                        state_d = WAIT_ACCEPT;
                    end else begin
                        state_d = IDLE;
                        idle_o  = 1'b1;
                    end
                end
            end

            WAIT_ACCEPT: begin
                data_valid_o     = 1'b1;
                illegal_access_o = held_illegal_q;
                if (!wait_i) begin
                    state_d = IDLE;
                    idle_o  = 1'b1;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    // ====================
    // Store buffer
    // ====================

    data_word_t buffer_forward_data;
    logic       buffer_match, held_match;

    store_buffer #(
        .DEPTH (STORE_BUFFER_DEPTH)
    ) store_buffer0 (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .push_i            (push),
        .push_data_i       (push_data),
        .push_address_i    (push_address),
        .push_width_i      (push_width),
        .full_o            (buffer_full),
        .empty_o           (buffer_empty_o),
        .validate_i        (validate_i),
        .store_request_o   (store_request_o),
        .store_address_o   (store_address_o),
        .store_data_o      (store_data_o),
        .store_width_o     (store_width_o),
        .store_done_i      (store_done_i),
        .forward_address_i (forward_address_i),
        .forward_data_o    (buffer_forward_data),
        .forward_match_o   (buffer_match)
    );

    // The stalled store is younger than anything in the buffer
    assign held_match      = (state_q == WAIT_BUFFER) &&
                             (held_address_q[31:2] == forward_address_i);
    assign forward_data_o  = held_match ? held_data_q : buffer_forward_data;
    assign forward_match_o = held_match || buffer_match;

    // A stalled store takes the slot freed by a retire in the very next cycle
    stall_resumes_after_retire: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ((state_q == WAIT_BUFFER) && store_done_i && !flush_i) |=> push
    ) else $error("store_unit: stalled store not pushed after a retire");

endmodule : store_unit
